// File: alu_settings.svh
// ######################################
// ALU settings
// widths shared by the packages and RTL
// ######################################

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

`define ALU_DATA_W  64 // operand width
`define ALU_HALF_W  32 // narrow op width
`define ALU_FUNC_W  4
`define ALU_CLASS_W 3
`define ALU_FLAG_W  6  // C O A S Z P

`endif

// File: alu_op_pkg.sv
// ######################################
// ALU operation types
// op word, class and function codes
// ######################################

`include "alu_settings.svh"

package alu_op_pkg;

  typedef enum logic [`ALU_CLASS_W-1:0] {
    CLS_ADD   = 3'd0,
    CLS_SUB   = 3'd1,
    CLS_LOGIC = 3'd2,
    CLS_MOVE  = 3'd3,
    CLS_CMOV  = 3'd4,
    CLS_CSET  = 3'd5
  } op_class_e;

  typedef enum logic [`ALU_FUNC_W-1:0] {
    F_AND  = 4'd0,
    F_OR   = 4'd1,
    F_XOR  = 4'd2,
    F_XNOR = 4'd3,
    F_ANDN = 4'd4 // a and not b
  } logic_func_e;

  typedef enum logic [`ALU_FUNC_W-1:0] {
    F_MOV   = 4'd0,
    F_ZXT8  = 4'd1,
    F_ZXT16 = 4'd2,
    F_ZXT32 = 4'd3,
    F_SXT8  = 4'd4,
    F_SXT16 = 4'd5,
    F_SXT32 = 4'd6
  } move_func_e;

  // add/sub func bit, set takes carry-in from flag C
  localparam int ARITH_CIN_BIT = 0;

  typedef struct packed {
    op_class_e               cls;
    logic                    wide; // 1 = 64 bit
    logic [`ALU_FUNC_W-1:0]  func;
  } alu_op_fields_t;

  typedef struct packed {
    op_class_e               cls;
    logic                    wide;
    logic [`ALU_FUNC_W-1:0]  cond; // condition code for cmov/cset
  } cond_op_fields_t;

  typedef union packed {
    alu_op_fields_t  f;
    cond_op_fields_t c;
  } alu_op_u;

endpackage

// File: alu_flag_pkg.sv
// ######################################
// ALU flag types
// flag word, conditions, unit results
// ######################################

`include "alu_settings.svh"

package alu_flag_pkg;

  typedef enum logic [3:0] {
    COND_Z, COND_NZ, COND_S, COND_NS,
    COND_UGT, COND_ULE, COND_UGE, COND_ULT,
    COND_SGT, COND_SLE, COND_SGE, COND_SLT,
    COND_O, COND_NO, COND_P, COND_ALWAYS
  } cond_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a; // nibble carry
    logic s;
    logic z;
    logic p; // parity even
  } flags_t;

  typedef struct packed {
    logic                   active;
    logic [`ALU_DATA_W-1:0] value;
    logic                   sign;
    logic                   carry;
    logic                   overflow;
    logic                   aux;
  } add_res_t;

  typedef struct packed {
    logic [`ALU_DATA_W-1:0] value;
    logic                   sign;
    logic                   keep_flags; // cmov/cset leave flags alone
  } logic_res_t;

  typedef struct packed {
    logic                   valid;
    logic [`ALU_DATA_W-1:0] result;
    flags_t                 flags;
  } alu_out_t;

endpackage

// File: cond_eval.sv
// ######################################
// condition evaluator
// tests one of 16 conditions on flags
// ######################################

`timescale 1ns/1ps

module cond_eval (
  input  alu_flag_pkg::flags_t flags,
  input  alu_flag_pkg::cond_e  cond,
  output logic                 taken
);

  always_comb
  begin
    taken = 1'b1;
    case (cond)
      alu_flag_pkg::COND_Z:      taken = flags.z;
      alu_flag_pkg::COND_NZ:     taken = ~flags.z;
      alu_flag_pkg::COND_S:      taken = flags.s;
      alu_flag_pkg::COND_NS:     taken = ~flags.s;
      // c set means no borrow
      alu_flag_pkg::COND_UGT:    taken = flags.c & ~flags.z;
      alu_flag_pkg::COND_ULE:    taken = ~flags.c | flags.z;
      alu_flag_pkg::COND_UGE:    taken = flags.c;
      alu_flag_pkg::COND_ULT:    taken = ~flags.c;
      alu_flag_pkg::COND_SGT:    taken = ~((flags.s ^ flags.o) | flags.z);
      alu_flag_pkg::COND_SLE:    taken = (flags.s ^ flags.o) | flags.z;
      alu_flag_pkg::COND_SGE:    taken = ~(flags.s ^ flags.o);
      alu_flag_pkg::COND_SLT:    taken = flags.s ^ flags.o;
      alu_flag_pkg::COND_O:      taken = flags.o;
      alu_flag_pkg::COND_NO:     taken = ~flags.o;
      alu_flag_pkg::COND_P:      taken = flags.p;
      alu_flag_pkg::COND_ALWAYS: taken = 1'b1;
      default:                   taken = 1'b1;
    endcase
  end

endmodule

// File: add_unit.sv
// ######################################
// adder unit
// 64/32 bit add and subtract with flags
// ######################################

`timescale 1ns/1ps
`include "alu_settings.svh"

module add_unit (
  input  alu_op_pkg::alu_op_u     op,
  input  logic [`ALU_DATA_W-1:0]  a,
  input  logic [`ALU_DATA_W-1:0]  b,
  input  logic                    carry_in,
  output alu_flag_pkg::add_res_t  res
);

  logic                   is_sub;
  logic                   use_cin;
  logic                   cin;
  logic [`ALU_DATA_W-1:0] b_op;
  logic [`ALU_DATA_W:0]   full_sum;
  logic [`ALU_HALF_W:0]   half_sum;
  logic [4:0]             nib_sum;
  logic                   ovf_full;
  logic                   ovf_half;

  assign is_sub  = (op.f.cls == alu_op_pkg::CLS_SUB);
  assign use_cin = op.f.func[alu_op_pkg::ARITH_CIN_BIT];

  // subtract is a + ~b + 1, or a + ~b + C with carry-in
  assign b_op = is_sub ? ~b : b;
  assign cin  = use_cin ? carry_in : is_sub;

  assign full_sum = {1'b0, a} + {1'b0, b_op} + {{`ALU_DATA_W{1'b0}}, cin};
  assign half_sum = {1'b0, a[`ALU_HALF_W-1:0]} + {1'b0, b_op[`ALU_HALF_W-1:0]}
                    + {{`ALU_HALF_W{1'b0}}, cin};
  assign nib_sum  = {1'b0, a[3:0]} + {1'b0, b_op[3:0]} + {4'b0, cin}; // carry out of bit 3

  assign ovf_full = (a[`ALU_DATA_W-1] == b_op[`ALU_DATA_W-1])
                    && (full_sum[`ALU_DATA_W-1] != a[`ALU_DATA_W-1]);
  assign ovf_half = (a[`ALU_HALF_W-1] == b_op[`ALU_HALF_W-1])
                    && (half_sum[`ALU_HALF_W-1] != a[`ALU_HALF_W-1]);

  always_comb
  begin
    res.active = (op.f.cls == alu_op_pkg::CLS_ADD) || is_sub;
    res.aux    = nib_sum[4];
    if (op.f.wide)
    begin
      res.value    = full_sum[`ALU_DATA_W-1:0];
      res.sign     = full_sum[`ALU_DATA_W-1];
      res.carry    = full_sum[`ALU_DATA_W];
      res.overflow = ovf_full;
    end
    else
    begin
      res.value    = {{(`ALU_DATA_W-`ALU_HALF_W){1'b0}}, half_sum[`ALU_HALF_W-1:0]};
      res.sign     = half_sum[`ALU_HALF_W-1];
      res.carry    = half_sum[`ALU_HALF_W];
      res.overflow = ovf_half;
    end
  end

endmodule

// File: logic_unit.sv
// ######################################
// logic unit
// logic, move/extend, cmov and cset
// ######################################

`timescale 1ns/1ps
`include "alu_settings.svh"

module logic_unit (
  input  alu_op_pkg::alu_op_u       op,
  input  logic [`ALU_DATA_W-1:0]    a,
  input  logic [`ALU_DATA_W-1:0]    b,
  input  alu_flag_pkg::flags_t      flags,
  output alu_flag_pkg::logic_res_t  res
);

  logic                   taken;
  logic [`ALU_DATA_W-1:0] logic_val;
  logic [`ALU_DATA_W-1:0] move_val;
  logic [`ALU_DATA_W-1:0] op_val;
  logic [`ALU_DATA_W-1:0] value;

  cond_eval u_cond (
    .flags (flags),
    .cond  (alu_flag_pkg::cond_e'(op.c.cond)),
    .taken (taken)
  );

  always_comb
  begin
    case (alu_op_pkg::logic_func_e'(op.f.func))
      alu_op_pkg::F_AND:  logic_val = a & b;
      alu_op_pkg::F_OR:   logic_val = a | b;
      alu_op_pkg::F_XOR:  logic_val = a ^ b;
      alu_op_pkg::F_XNOR: logic_val = ~(a ^ b);
      alu_op_pkg::F_ANDN: logic_val = a & ~b;
      default:            logic_val = '0;
    endcase
  end

  // source is always b
  always_comb
  begin
    case (alu_op_pkg::move_func_e'(op.f.func))
      alu_op_pkg::F_MOV:   move_val = b;
      alu_op_pkg::F_ZXT8:  move_val = {{(`ALU_DATA_W-8){1'b0}}, b[7:0]};
      alu_op_pkg::F_ZXT16: move_val = {{(`ALU_DATA_W-16){1'b0}}, b[15:0]};
      alu_op_pkg::F_ZXT32: move_val = {{(`ALU_DATA_W-32){1'b0}}, b[31:0]};
      alu_op_pkg::F_SXT8:  move_val = {{(`ALU_DATA_W-8){b[7]}}, b[7:0]};
      alu_op_pkg::F_SXT16: move_val = {{(`ALU_DATA_W-16){b[15]}}, b[15:0]};
      alu_op_pkg::F_SXT32: move_val = {{(`ALU_DATA_W-32){b[31]}}, b[31:0]};
      default:             move_val = '0;
    endcase
  end

  always_comb
  begin
    case (op.f.cls)
      alu_op_pkg::CLS_LOGIC: op_val = logic_val;
      alu_op_pkg::CLS_MOVE:  op_val = move_val;
      alu_op_pkg::CLS_CMOV:  op_val = taken ? b : a;
      alu_op_pkg::CLS_CSET:  op_val = {{(`ALU_DATA_W-1){1'b0}}, taken};
      default:               op_val = '0; // add/sub handled by the adder
    endcase
  end

  // narrow ops clear the upper half
  assign value = op.f.wide ? op_val
                 : {{(`ALU_DATA_W-`ALU_HALF_W){1'b0}}, op_val[`ALU_HALF_W-1:0]};

  assign res.value      = value;
  assign res.sign       = op.f.wide ? value[`ALU_DATA_W-1] : value[`ALU_HALF_W-1];
  assign res.keep_flags = (op.f.cls == alu_op_pkg::CLS_CMOV)
                          || (op.f.cls == alu_op_pkg::CLS_CSET);

endmodule

// File: result_stage.sv
// ######################################
// result stage
// picks unit result, forms flags, regs
// ######################################

`timescale 1ns/1ps
`include "alu_settings.svh"

module result_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  alu_flag_pkg::add_res_t    add_res,
  input  alu_flag_pkg::logic_res_t  logic_res,
  input  alu_flag_pkg::flags_t      flags,
  output alu_flag_pkg::alu_out_t    out
);

  logic [`ALU_DATA_W-1:0] sel_value;
  logic                   sel_sign;
  alu_flag_pkg::flags_t   next_flags;

  assign sel_value = add_res.active ? add_res.value : logic_res.value;
  assign sel_sign  = add_res.active ? add_res.sign : logic_res.sign;

  always_comb
  begin
    next_flags.s = sel_sign;
    next_flags.z = (sel_value == '0);
    next_flags.p = ~^sel_value[7:0]; // even parity, low byte
    if (add_res.active)
    begin
      next_flags.c = add_res.carry;
      next_flags.o = add_res.overflow;
      next_flags.a = add_res.aux;
    end
    else
    begin
      next_flags.c = 1'b0;
      next_flags.o = 1'b0;
      next_flags.a = 1'b0;
    end
    if (logic_res.keep_flags && !add_res.active)
      next_flags = flags; // cmov/cset pass flags through
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out.valid  <= 1'b0;
      out.result <= '0;
      out.flags  <= alu_flag_pkg::flags_t'({`ALU_FLAG_W{1'b0}});
    end
    else
    begin
      out.valid  <= in_valid;
      out.result <= sel_value;
      out.flags  <= next_flags;
    end
  end

endmodule

// File: alu_top.sv
// ######################################
// ALU top level
// adder and logic unit into result stage
// ######################################

`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  alu_op_pkg::alu_op_u     op,
  input  logic [`ALU_DATA_W-1:0]  a,
  input  logic [`ALU_DATA_W-1:0]  b,
  input  alu_flag_pkg::flags_t    flags_in,
  output alu_flag_pkg::alu_out_t  out
);

  alu_flag_pkg::add_res_t   add_res;
  alu_flag_pkg::logic_res_t logic_res;

  add_unit u_add (
    .op       (op),
    .a        (a),
    .b        (b),
    .carry_in (flags_in.c),
    .res      (add_res)
  );

  logic_unit u_logic (
    .op    (op),
    .a     (a),
    .b     (b),
    .flags (flags_in),
    .res   (logic_res)
  );

  result_stage u_result (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .add_res   (add_res),
    .logic_res (logic_res),
    .flags     (flags_in),
    .out       (out)
  );

endmodule

// File: tb_alu.sv
// ######################################
// ALU testbench
// random and directed ops vs a model
// ######################################

`timescale 1ns/1ps
`include "alu_settings.svh"

module tb_alu;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  alu_op_pkg::alu_op_u    op;
  logic [`ALU_DATA_W-1:0] a;
  logic [`ALU_DATA_W-1:0] b;
  alu_flag_pkg::flags_t   flags_in;
  alu_flag_pkg::alu_out_t out;

  alu_flag_pkg::alu_out_t exp_q[$]; // one cycle behind the inputs
  string                  name_q[$];
  integer                 seed;

  alu_top UUT (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .op       (op),
    .a        (a),
    .b        (b),
    .flags_in (flags_in),
    .out      (out)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
  end

  // odd code inverts the even code below it
  function automatic logic cond_holds(alu_flag_pkg::flags_t f, logic [3:0] code);
    logic base;
    case (code[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.s;
      3'd2:    base = f.c & ~f.z;
      3'd3:    base = f.c;
      3'd4:    base = (f.s == f.o) & ~f.z;
      3'd5:    base = (f.s == f.o);
      3'd6:    base = f.o;
      default: base = f.p;
    endcase
    if (code == 4'd15)
      return 1'b1;
    return base ^ code[0];
  endfunction

  function automatic logic even_parity(logic [7:0] v);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += int'(v[i]);
    return (ones % 2) == 0;
  endfunction

  function automatic alu_flag_pkg::alu_out_t model_alu(alu_op_pkg::alu_op_u o,
      logic [63:0] x, logic [63:0] y, alu_flag_pkg::flags_t f);
    alu_flag_pkg::alu_out_t r;
    logic [63:0] yy;
    logic [63:0] v;
    logic [64:0] usum;
    logic [64:0] ssum;
    logic        cin;
    logic        is_sub;
    int          n;
    r = '0;
    v = '0;
    r.valid = 1'b1;
    is_sub = (o.f.cls == alu_op_pkg::CLS_SUB);
    yy = is_sub ? ~y : y;
    cin = o.f.func[0] ? f.c : is_sub;
    case (o.f.cls)
      alu_op_pkg::CLS_ADD, alu_op_pkg::CLS_SUB:
      begin
        if (o.f.wide)
        begin
          usum = {1'b0, x} + {1'b0, yy} + 65'(cin);
          ssum = {x[63], x} + {yy[63], yy} + 65'(cin);
          r.flags.c = usum[64];
          r.flags.o = ssum[64] != ssum[63];
          v = usum[63:0];
        end
        else
        begin
          usum = {33'b0, x[31:0]} + {33'b0, yy[31:0]} + 65'(cin);
          ssum = {{33{x[31]}}, x[31:0]} + {{33{yy[31]}}, yy[31:0]} + 65'(cin);
          r.flags.c = usum[32];
          r.flags.o = ssum[32] != ssum[31];
          v = {32'b0, usum[31:0]};
        end
        r.flags.a = x[4] ^ yy[4] ^ usum[4]; // carry into bit 4
      end
      alu_op_pkg::CLS_LOGIC:
        case (o.f.func)
          alu_op_pkg::F_AND:  v = x & y;
          alu_op_pkg::F_OR:   v = x | y;
          alu_op_pkg::F_XOR:  v = x ^ y;
          alu_op_pkg::F_XNOR: v = ~(x ^ y);
          default:            v = x & ~y;
        endcase
      alu_op_pkg::CLS_MOVE:
      begin
        case (o.f.func)
          alu_op_pkg::F_ZXT8, alu_op_pkg::F_SXT8:   n = 8;
          alu_op_pkg::F_ZXT16, alu_op_pkg::F_SXT16: n = 16;
          default:                                  n = 32;
        endcase
        if (o.f.func == alu_op_pkg::F_MOV)
          v = y;
        else if (o.f.func <= alu_op_pkg::F_ZXT32)
          v = y & ((64'd1 << n) - 64'd1);
        else
          v = $signed(y << (64 - n)) >>> (64 - n);
      end
      alu_op_pkg::CLS_CMOV: v = cond_holds(f, o.c.cond) ? y : x;
      default:              v = 64'(cond_holds(f, o.c.cond));
    endcase
    if (!o.f.wide)
      v[63:32] = 32'b0;
    r.result = v;
    if (o.f.cls == alu_op_pkg::CLS_CMOV || o.f.cls == alu_op_pkg::CLS_CSET)
      r.flags = f;
    else
    begin
      r.flags.s = o.f.wide ? v[63] : v[31];
      r.flags.z = (v == 64'd0);
      r.flags.p = even_parity(v[7:0]);
    end
    return r;
  endfunction

  task automatic compare_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic check_front();
    alu_flag_pkg::alu_out_t e;
    string name;
    e = exp_q.pop_front();
    name = name_q.pop_front();
    compare_value({name, " valid"}, {63'b0, e.valid}, {63'b0, out.valid});
    if (e.valid)
    begin
      compare_value({name, " result"}, e.result, out.result);
      compare_value({name, " flags"}, {58'b0, e.flags}, {58'b0, out.flags});
    end
  endtask

  // check last cycle's output and drive the next op
  task automatic run_cycle(string name, logic valid, logic [2:0] cls, logic wide,
                           logic [3:0] func, logic [63:0] x, logic [63:0] y,
                           alu_flag_pkg::flags_t f);
    alu_op_pkg::alu_op_u    o;
    alu_flag_pkg::alu_out_t e;
    @(posedge clk);
    #1;
    check_front();
    o.f.cls = alu_op_pkg::op_class_e'(cls);
    o.f.wide = wide;
    o.f.func = func;
    in_valid = valid;
    op = o;
    a = x;
    b = y;
    flags_in = f;
    e = model_alu(o, x, y, f);
    e.valid = valid;
    exp_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic random_op(int idx);
    logic [31:0] rnd;
    logic [63:0] x;
    logic [63:0] y;
    logic [3:0]  func;
    int          cls;
    rnd = $random(seed);
    cls = $unsigned($random(seed)) % 6;
    x = {$random(seed), $random(seed)};
    y = {$random(seed), $random(seed)};
    if (rnd[10:8] == 3'd0)
      y = x; // hits zero results on sub and xor
    case (cls)
      0, 1:    func = {3'b0, rnd[4]};
      2:       func = 4'($unsigned($random(seed)) % 5);
      3:       func = 4'($unsigned($random(seed)) % 7);
      default: func = rnd[15:12];
    endcase
    run_cycle($sformatf("random op %0d class %0d", idx, cls), rnd[1:0] != 2'b00,
              cls[2:0], rnd[2], func, x, y, alu_flag_pkg::flags_t'(rnd[21:16]));
  endtask

  task automatic run_tests();
    logic [31:0] rnd;
    compare_value("reset valid", 64'd0, {63'b0, out.valid});
    compare_value("reset result", 64'd0, out.result);
    compare_value("reset flags", 64'd0, {58'b0, out.flags});
    exp_q.push_back('0);
    name_q.push_back("after reset");
    run_cycle("add64 max plus 1", 1'b1, 3'd0, 1'b1, 4'd0, '1, 64'd1, '0);
    run_cycle("add32 max plus 1", 1'b1, 3'd0, 1'b0, 4'd0, 64'hffff_ffff, 64'd1, '0);
    run_cycle("sub64 0 minus 1", 1'b1, 3'd1, 1'b1, 4'd0, 64'd0, 64'd1, '0);
    run_cycle("sub32 0 minus 1", 1'b1, 3'd1, 1'b0, 4'd0, 64'd0, 64'd1, '0);
    run_cycle("add64 signed overflow", 1'b1, 3'd0, 1'b1, 4'd0,
              64'h7fff_ffff_ffff_ffff, 64'd1, '0);
    run_cycle("add64 carry in", 1'b1, 3'd0, 1'b1, 4'd1, '1, 64'd0,
              alu_flag_pkg::flags_t'(6'b100000));
    run_cycle("sub64 borrow in", 1'b1, 3'd1, 1'b1, 4'd1, 64'd5, 64'd3, '0);
    run_cycle("sub32 same operands", 1'b1, 3'd1, 1'b0, 4'd0, 64'h1234, 64'h1234, '0);
    for (int w = 0; w < 2; w++)
    begin
      for (int fn = 0; fn < 5; fn++)
        run_cycle($sformatf("logic func %0d wide %0d", fn, w), 1'b1, 3'd2, w[0],
                  fn[3:0], {$random(seed), $random(seed)}, {$random(seed), $random(seed)}, '0);
      for (int fn = 0; fn < 7; fn++)
        run_cycle($sformatf("move func %0d wide %0d", fn, w), 1'b1, 3'd3, w[0],
                  fn[3:0], {$random(seed), $random(seed)}, {$random(seed), $random(seed)}, '0);
    end
    for (int cc = 0; cc < 16; cc++)
    begin
      rnd = $random(seed);
      run_cycle($sformatf("cmov cond %0d", cc), 1'b1, 3'd4, rnd[8], cc[3:0],
                {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                alu_flag_pkg::flags_t'(rnd[5:0]));
      rnd = $random(seed);
      run_cycle($sformatf("cset cond %0d", cc), 1'b1, 3'd5, rnd[8], cc[3:0],
                {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                alu_flag_pkg::flags_t'(rnd[5:0]));
    end
    run_cycle("idle", 1'b0, 3'd2, 1'b1, 4'd0, '1, '1, '0);
    for (int i = 0; i < 2000; i++)
      random_op(i);
    run_cycle("idle", 1'b0, 3'd0, 1'b1, 4'd0, '0, '0, '0);
    @(posedge clk);
    #1;
    check_front();
  endtask

  initial
  begin
    int timeout;
    seed = 32'h19e7_5ee9;
    in_valid = 1'b0;
    op = '0;
    a = '0;
    b = '0;
    flags_in = '0;
    timeout = 0;
    while (rst !== 1'b0 && timeout < 20)
    begin
      @(negedge clk);
      timeout++;
    end
    if (rst !== 1'b0)
    begin
      $display("timeout while waiting for reset to be released");
      $display("Regression failed");
      $fatal(1, "reset timeout");
    end
    else
    begin
      run_tests();
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: alu.f
+incdir+.
alu_op_pkg.sv
alu_flag_pkg.sv
cond_eval.sv
add_unit.sv
logic_unit.sv
result_stage.sv
alu_top.sv
tb_alu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the ALU testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_alu -f alu.f -o Vtb_alu

./obj_dir/Vtb_alu > sim.log 2>&1 || echo "simulator exited with a non-zero status"
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if ! grep -q "Regression passed" sim.log; then
  echo "no pass line found in sim.log"
  exit 1
fi
exit 0
